// ==== logic/frontEnd_settings.svh ====
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// byte address of the first fetch.
`define RESET_PC 32'h0000_0100

// instruction and data word.
`define WORD_WIDTH 32

// 16 architectural registers.
`define REG_INDEX_WIDTH 4

// wishbone byte address.
`define MEM_ADDR_WIDTH 32

`endif

// ==== logic/cpuPkg.sv ====
`include "frontEnd_settings.svh"

package cpuPkg;

        // bit 0 of every opcode selects the format, 1 for immediate.
        typedef enum logic [7:0] {
                OP_NOP_R = 8'h00,
                OP_ADD_R = 8'h02,
                OP_ADD_I = 8'h03,
                OP_ADC_R = 8'h04,
                OP_ADC_I = 8'h05,
                OP_SUB_R = 8'h06,
                OP_SUB_I = 8'h07,
                OP_SBB_R = 8'h08,
                OP_SBB_I = 8'h09,
                OP_AND_R = 8'h0a,
                OP_AND_I = 8'h0b,
                OP_OR_R  = 8'h0c,
                OP_OR_I  = 8'h0d,
                OP_XOR_R = 8'h0e,
                OP_XOR_I = 8'h0f,
                OP_CMP_R = 8'h10,
                OP_CMP_I = 8'h11,
                OP_SHL_R = 8'h12,
                OP_SHL_I = 8'h13,
                OP_SHR_R = 8'h14,
                OP_SHR_I = 8'h15,
                OP_SAR_R = 8'h16,
                OP_SAR_I = 8'h17,
                OP_ROL_R = 8'h18,
                OP_ROL_I = 8'h19,
                OP_NOT_R = 8'h1a
        } opcodes;

        // one-hot class, all zeros for an undefined opcode.
        typedef enum logic [25:0] {
                XXX   = 26'b0,
                ADC_I = 26'b1 << 0,
                ADC_R = 26'b1 << 1,
                ADD_I = 26'b1 << 2,
                ADD_R = 26'b1 << 3,
                AND_I = 26'b1 << 4,
                AND_R = 26'b1 << 5,
                CMP_I = 26'b1 << 6,
                CMP_R = 26'b1 << 7,
                NOP_R = 26'b1 << 8,
                NOT_R = 26'b1 << 9,
                OR_I  = 26'b1 << 10,
                OR_R  = 26'b1 << 11,
                ROL_I = 26'b1 << 12,
                ROL_R = 26'b1 << 13,
                SAR_I = 26'b1 << 14,
                SAR_R = 26'b1 << 15,
                SBB_I = 26'b1 << 16,
                SBB_R = 26'b1 << 17,
                SHL_I = 26'b1 << 18,
                SHL_R = 26'b1 << 19,
                SHR_I = 26'b1 << 20,
                SHR_R = 26'b1 << 21,
                SUB_I = 26'b1 << 22,
                SUB_R = 26'b1 << 23,
                XOR_I = 26'b1 << 24,
                XOR_R = 26'b1 << 25
        } instructions;

        // register form.
        typedef struct packed {
                opcodes                      opcode;
                logic [`REG_INDEX_WIDTH-1:0] rd;
                logic [`REG_INDEX_WIDTH-1:0] ra;
                logic [`REG_INDEX_WIDTH-1:0] rb;
                logic [`WORD_WIDTH-8-3*`REG_INDEX_WIDTH-1:0] reserved;
        } rFormWord;

        // immediate form, same opcode, rd and ra positions.
        typedef struct packed {
                opcodes                      opcode;
                logic [`REG_INDEX_WIDTH-1:0] rd;
                logic [`REG_INDEX_WIDTH-1:0] ra;
                logic [`WORD_WIDTH-8-2*`REG_INDEX_WIDTH-1:0] imm;
        } iFormWord;

        typedef union packed {
                rFormWord rForm;
                iFormWord iForm;
        } instructionWord;

endpackage

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module fetchStage (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       stall,
        input  logic                       wbAck,
        input  logic [`WORD_WIDTH-1:0]     wbDatIn,
        output logic                       wbCyc,
        output logic                       wbStb,
        output logic                       wbWe,
        output logic [`MEM_ADDR_WIDTH-1:0] wbAdr,
        output logic                       fetchValid,
        output cpuPkg::instructionWord     fetchWord
);

        typedef enum logic [1:0] {
                IDLE,
                REQUEST,
                WAIT_ACK
        } busState;

        busState                    state;
        logic [`MEM_ADDR_WIDTH-1:0] pc;
        logic                       bufferFree;
        logic                       ackTaken;

        // buffer is empty or drains on this edge.
        assign bufferFree = !fetchValid || !stall;
        assign ackTaken   = (state != IDLE) && wbAck;

        // classic cycle, cyc and stb together.
        assign wbCyc = (state != IDLE);
        assign wbStb = (state != IDLE);
        assign wbWe  = 1'b0;
        assign wbAdr = pc;

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= IDLE;
                        pc    <= `RESET_PC;
                end else begin
                        case (state)
                                IDLE: begin
                                        if (bufferFree)
                                                state <= REQUEST;
                                end
                                REQUEST: begin
                                        state <= wbAck ? IDLE : WAIT_ACK;
                                end
                                WAIT_ACK: begin
                                        if (wbAck)
                                                state <= IDLE;
                                end
                                default: state <= IDLE;
                        endcase
                        // no branches, so strictly sequential.
                        if (ackTaken)
                                pc <= pc + `MEM_ADDR_WIDTH'(4);
                end
        end

        always_ff @(posedge clk) begin
                if (reset)
                        fetchValid <= 1'b0;
                else if (ackTaken)
                        fetchValid <= 1'b1;
                else if (!stall)
                        fetchValid <= 1'b0;
        end

        always_ff @(posedge clk) begin
                if (ackTaken)
                        fetchWord <= wbDatIn;
        end

endmodule

// ==== logic/instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   stall,
        input  logic                   fetchValid,
        input  cpuPkg::instructionWord fetchWord,
        output logic                   decValid,
        output cpuPkg::instructions    decInstruction,
        output cpuPkg::instructionWord decWord
);

        cpuPkg::instructions instruction;

        // opcode sits in the same place in both forms.
        always_comb begin
                instruction = cpuPkg::XXX;

                case (fetchWord.rForm.opcode)
                        cpuPkg::OP_ADC_I: instruction = cpuPkg::ADC_I;
                        cpuPkg::OP_ADC_R: instruction = cpuPkg::ADC_R;
                        cpuPkg::OP_ADD_I: instruction = cpuPkg::ADD_I;
                        cpuPkg::OP_ADD_R: instruction = cpuPkg::ADD_R;
                        cpuPkg::OP_AND_I: instruction = cpuPkg::AND_I;
                        cpuPkg::OP_AND_R: instruction = cpuPkg::AND_R;
                        cpuPkg::OP_CMP_I: instruction = cpuPkg::CMP_I;
                        cpuPkg::OP_CMP_R: instruction = cpuPkg::CMP_R;
                        cpuPkg::OP_NOP_R: instruction = cpuPkg::NOP_R;
                        cpuPkg::OP_NOT_R: instruction = cpuPkg::NOT_R;
                        cpuPkg::OP_OR_I:  instruction = cpuPkg::OR_I;
                        cpuPkg::OP_OR_R:  instruction = cpuPkg::OR_R;
                        cpuPkg::OP_ROL_I: instruction = cpuPkg::ROL_I;
                        cpuPkg::OP_ROL_R: instruction = cpuPkg::ROL_R;
                        cpuPkg::OP_SAR_I: instruction = cpuPkg::SAR_I;
                        cpuPkg::OP_SAR_R: instruction = cpuPkg::SAR_R;
                        cpuPkg::OP_SBB_I: instruction = cpuPkg::SBB_I;
                        cpuPkg::OP_SBB_R: instruction = cpuPkg::SBB_R;
                        cpuPkg::OP_SHL_I: instruction = cpuPkg::SHL_I;
                        cpuPkg::OP_SHL_R: instruction = cpuPkg::SHL_R;
                        cpuPkg::OP_SHR_I: instruction = cpuPkg::SHR_I;
                        cpuPkg::OP_SHR_R: instruction = cpuPkg::SHR_R;
                        cpuPkg::OP_SUB_I: instruction = cpuPkg::SUB_I;
                        cpuPkg::OP_SUB_R: instruction = cpuPkg::SUB_R;
                        cpuPkg::OP_XOR_I: instruction = cpuPkg::XOR_I;
                        cpuPkg::OP_XOR_R: instruction = cpuPkg::XOR_R;
                        default:          instruction = cpuPkg::XXX;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset)
                        decValid <= 1'b0;
                else if (!stall)
                        decValid <= fetchValid;
        end

        // class and word move together.
        always_ff @(posedge clk) begin
                if (!stall) begin
                        decInstruction <= instruction;
                        decWord        <= fetchWord;
                end
        end

endmodule

// ==== logic/operandStage.sv ====
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module operandStage (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        stall,
        input  logic                        decValid,
        input  cpuPkg::instructions         decInstruction,
        input  cpuPkg::instructionWord      decWord,
        output logic                        outValid,
        output cpuPkg::instructions         outInstruction,
        output logic [`REG_INDEX_WIDTH-1:0] outRd,
        output logic [`REG_INDEX_WIDTH-1:0] outRa,
        output logic [`WORD_WIDTH-1:0]      outOperand,
        output logic                        outImmediate
);

        logic                  immForm;
        logic [`WORD_WIDTH-1:0] operand;

        assign immForm = decWord.rForm.opcode[0];

        // second operand through the matching view.
        always_comb begin
                if (immForm)
                        operand = `WORD_WIDTH'($signed(decWord.iForm.imm));
                else
                        operand = `WORD_WIDTH'(decWord.rForm.rb);
        end

        always_ff @(posedge clk) begin
                if (reset)
                        outValid <= 1'b0;
                else if (!stall)
                        outValid <= decValid;
        end

        always_ff @(posedge clk) begin
                if (!stall) begin
                        outInstruction <= decInstruction;
                        outRd          <= decWord.rForm.rd;
                        outRa          <= decWord.rForm.ra;
                        outOperand     <= operand;
                        outImmediate   <= immForm;
                end
        end

endmodule

// ==== logic/frontEnd.sv ====
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module frontEnd (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        stall,
        input  logic                        wbAck,
        input  logic [`WORD_WIDTH-1:0]      wbDatIn,
        output logic                        wbCyc,
        output logic                        wbStb,
        output logic                        wbWe,
        output logic [`MEM_ADDR_WIDTH-1:0]  wbAdr,
        output logic                        outValid,
        output cpuPkg::instructions         outInstruction,
        output logic [`REG_INDEX_WIDTH-1:0] outRd,
        output logic [`REG_INDEX_WIDTH-1:0] outRa,
        output logic [`WORD_WIDTH-1:0]      outOperand,
        output logic                        outImmediate
);

        logic                   fetchValid;
        cpuPkg::instructionWord fetchWord;
        logic                   decValid;
        cpuPkg::instructions    decInstruction;
        cpuPkg::instructionWord decWord;

        fetchStage i_fetchStage (
                .clk        (clk),
                .reset      (reset),
                .stall      (stall),
                .wbAck      (wbAck),
                .wbDatIn    (wbDatIn),
                .wbCyc      (wbCyc),
                .wbStb      (wbStb),
                .wbWe       (wbWe),
                .wbAdr      (wbAdr),
                .fetchValid (fetchValid),
                .fetchWord  (fetchWord)
        );

        instructionDecoder i_instructionDecoder (
                .clk            (clk),
                .reset          (reset),
                .stall          (stall),
                .fetchValid     (fetchValid),
                .fetchWord      (fetchWord),
                .decValid       (decValid),
                .decInstruction (decInstruction),
                .decWord        (decWord)
        );

        operandStage i_operandStage (
                .clk            (clk),
                .reset          (reset),
                .stall          (stall),
                .decValid       (decValid),
                .decInstruction (decInstruction),
                .decWord        (decWord),
                .outValid       (outValid),
                .outInstruction (outInstruction),
                .outRd          (outRd),
                .outRa          (outRa),
                .outOperand     (outOperand),
                .outImmediate   (outImmediate)
        );

endmodule

// ==== dv/frontEnd_chk.sv ====
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module frontEnd_chk (
        input logic                        clk,
        input logic                        reset,
        input logic                        stall,
        input logic                        wbCyc,
        input logic                        wbStb,
        input logic                        wbWe,
        input logic                        wbAck,
        input logic [`MEM_ADDR_WIDTH-1:0]  wbAdr,
        input logic                        outValid,
        input cpuPkg::instructions         outInstruction,
        input logic [`REG_INDEX_WIDTH-1:0] outRd,
        input logic [`REG_INDEX_WIDTH-1:0] outRa,
        input logic [`WORD_WIDTH-1:0]      outOperand,
        input logic                        outImmediate
);

        stbNeedsCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
                else $error("wishbone strobe without cycle");

        // request held with the same address until ack.
        stbHeld: assert property (@(posedge clk) disable iff (reset)
                wbStb && !wbAck |=> wbStb && $stable(wbAdr))
                else $error("wishbone request dropped or address changed before ack");

        neverWrite: assert property (@(posedge clk) !wbWe)
                else $error("wishbone write from the fetch master");

        outputHeld: assert property (@(posedge clk) disable iff (reset)
                outValid && stall |=> outValid && $stable(outInstruction) && $stable(outRd)
                        && $stable(outRa) && $stable(outOperand) && $stable(outImmediate))
                else $error("output changed while stalled");

        resetValues: assert property (@(posedge clk) reset |=> !outValid && !wbCyc && !wbStb)
                else $error("valid or bus request high right after reset");

endmodule

// ==== dv/frontEnd_tb.sv ====
`timescale 1ns/1ps
`include "frontEnd_settings.svh"

module frontEnd_tb;

        localparam int MAX_CASES = 64;
        localparam int FIELDS    = 6;

        logic                        clk;
        logic                        reset;
        logic                        stall;
        logic                        wbAck;
        logic [`WORD_WIDTH-1:0]      wbDatIn;
        logic                        wbCyc;
        logic                        wbStb;
        logic                        wbWe;
        logic [`MEM_ADDR_WIDTH-1:0]  wbAdr;
        logic                        outValid;
        cpuPkg::instructions         outInstruction;
        logic [`REG_INDEX_WIDTH-1:0] outRd;
        logic [`REG_INDEX_WIDTH-1:0] outRa;
        logic [`WORD_WIDTH-1:0]      outOperand;
        logic                        outImmediate;

        // word, class, rd, ra, operand, immediate flag.
        logic [31:0] caseData [0:MAX_CASES*FIELDS-1];
        int          numCases;
        int          checkedCount;
        int          passCount;
        int          failCount;
        int          busErrors;
        int          transferCount;
        int          waitLeft;
        bit          busy;
        bit          ackSeen;

        frontEnd i_dut (
                .clk            (clk),
                .reset          (reset),
                .stall          (stall),
                .wbAck          (wbAck),
                .wbDatIn        (wbDatIn),
                .wbCyc          (wbCyc),
                .wbStb          (wbStb),
                .wbWe           (wbWe),
                .wbAdr          (wbAdr),
                .outValid       (outValid),
                .outInstruction (outInstruction),
                .outRd          (outRd),
                .outRa          (outRa),
                .outOperand     (outOperand),
                .outImmediate   (outImmediate)
        );

        bind frontEnd frontEnd_chk i_frontEndChk (
                .clk            (clk),
                .reset          (reset),
                .stall          (stall),
                .wbCyc          (wbCyc),
                .wbStb          (wbStb),
                .wbWe           (wbWe),
                .wbAck          (wbAck),
                .wbAdr          (wbAdr),
                .outValid       (outValid),
                .outInstruction (outInstruction),
                .outRd          (outRd),
                .outRa          (outRa),
                .outOperand     (outOperand),
                .outImmediate   (outImmediate)
        );

        always #50 clk = ~clk;

        task automatic compareInstruction(input int caseIndex,
                                          input cpuPkg::instructions expected,
                                          input cpuPkg::instructions actual, output bit ok);
                ok = 1'b1;
                if (actual !== expected) begin
                        $display("mismatch at %0t: case %0d class expected %h got %h",
                                 $time, caseIndex, expected, actual);
                        ok = 1'b0;
                end
        endtask

        task automatic compareOperands(input int caseIndex,
                                       input logic [`REG_INDEX_WIDTH-1:0] expRd, expRa,
                                       input logic [`WORD_WIDTH-1:0] expOperand,
                                       input logic expImmediate,
                                       input logic [`REG_INDEX_WIDTH-1:0] actRd, actRa,
                                       input logic [`WORD_WIDTH-1:0] actOperand,
                                       input logic actImmediate, output bit ok);
                ok = 1'b1;
                if (actRd !== expRd || actRa !== expRa) begin
                        $display("mismatch at %0t: case %0d rd/ra expected %h/%h got %h/%h",
                                 $time, caseIndex, expRd, expRa, actRd, actRa);
                        ok = 1'b0;
                end
                if (actOperand !== expOperand || actImmediate !== expImmediate) begin
                        $display({"mismatch at %0t: case %0d operand expected %h imm %b",
                                  " got %h imm %b"}, $time, caseIndex, expOperand,
                                 expImmediate, actOperand, actImmediate);
                        ok = 1'b0;
                end
        endtask

        task automatic compareAddress(input int transfer,
                                      input logic [`MEM_ADDR_WIDTH-1:0] expected,
                                      input logic [`MEM_ADDR_WIDTH-1:0] actual, output bit ok);
                ok = 1'b1;
                if (actual !== expected) begin
                        $display("mismatch at %0t: transfer %0d address expected %h got %h",
                                 $time, transfer, expected, actual);
                        ok = 1'b0;
                end
        endtask

        // words past the last case are filled from the address.
        function automatic logic [`WORD_WIDTH-1:0] wordAt(
                input logic [`MEM_ADDR_WIDTH-1:0] adr);
                int index;
                index = int'((adr - `RESET_PC) >> 2);
                if (adr >= `RESET_PC && index < numCases)
                        return caseData[index*FIELDS];
                return ~adr;
        endfunction

        // random stall about 30 percent of the time.
        always @(posedge clk) begin
                if (reset)
                        stall <= 1'b0;
                else
                        stall <= ($urandom % 10) < 3;
        end

        // wishbone slave with 0 to 3 wait states.
        always @(posedge clk) begin
                logic [`MEM_ADDR_WIDTH-1:0] expectedAdr;
                bit                         adrOk;
                if (reset) begin
                        wbAck <= 1'b0;
                        busy = 1'b0;
                        transferCount = 0;
                end else begin
                        wbAck <= 1'b0;
                        if (wbAck)
                                ackSeen <= 1'b1;
                        if (wbCyc && wbStb && !wbAck) begin
                                if (!busy) begin
                                        busy = 1'b1;
                                        waitLeft = $urandom % 4;
                                        expectedAdr = `RESET_PC + 4 * transferCount;
                                        compareAddress(transferCount, expectedAdr, wbAdr, adrOk);
                                        if (!adrOk)
                                                busErrors++;
                                        transferCount++;
                                end
                                if (waitLeft == 0) begin
                                        wbAck <= 1'b1;
                                        wbDatIn <= wordAt(wbAdr);
                                        busy = 1'b0;
                                end else begin
                                        waitLeft--;
                                end
                        end
                end
        end

        // takes one case per accepted output.
        always @(posedge clk) begin
                int base;
                bit classOk;
                bit fieldsOk;
                if (!reset && outValid && !ackSeen) begin
                        $display("output valid at %0t before the first bus acknowledge", $time);
                        failCount++;
                end
                if (!reset && outValid && !stall && checkedCount < numCases) begin
                        base = checkedCount * FIELDS;
                        compareInstruction(checkedCount,
                                           cpuPkg::instructions'(caseData[base+1][25:0]),
                                           outInstruction, classOk);
                        compareOperands(checkedCount, caseData[base+2][`REG_INDEX_WIDTH-1:0],
                                        caseData[base+3][`REG_INDEX_WIDTH-1:0],
                                        caseData[base+4], caseData[base+5][0],
                                        outRd, outRa, outOperand, outImmediate, fieldsOk);
                        if (classOk && fieldsOk) begin
                                passCount++;
                                $display("case %0d ok, word %h", checkedCount, caseData[base]);
                        end else begin
                                failCount++;
                                $display("case %0d failed, word %h", checkedCount, caseData[base]);
                        end
                        checkedCount <= checkedCount + 1;
                end
        end

        initial begin
                int i;
                int cycles;
                int cycleLimit;
                bit timedOut;
                clk = 1'b0;
                reset = 1'b1;
                stall = 1'b0;
                wbAck = 1'b0;
                wbDatIn = '0;
                numCases = 0;
                checkedCount = 0;
                passCount = 0;
                failCount = 0;
                busErrors = 0;
                ackSeen = 1'b0;
                timedOut = 1'b0;
                void'($urandom(81));
                for (i = 0; i < MAX_CASES * FIELDS; i++)
                        caseData[i] = 32'hffff_ffff;
                $readmemh("dv/frontEnd_cases.txt", caseData);
                // class column never holds all ones for a real case.
                while (numCases < MAX_CASES && caseData[numCases*FIELDS+1] != 32'hffff_ffff)
                        numCases++;
                if (numCases == 0)
                        $display("no cases were read from the cases file");
                cycleLimit = numCases * (3 + 10 + 4) + 20;

                repeat (2) @(posedge clk);
                reset <= 1'b0;
                cycles = 0;
                while (checkedCount < numCases && cycles < cycleLimit) begin
                        @(posedge clk);
                        cycles++;
                end
                @(negedge clk);
                if (checkedCount < numCases) begin
                        timedOut = 1'b1;
                        $display("timeout: only %0d of %0d cases came out within %0d cycles",
                                 checkedCount, numCases, cycleLimit);
                end
                $display("cases passed %0d failed %0d, bus errors %0d",
                         passCount, failCount, busErrors);
                if (numCases > 0 && !timedOut && failCount == 0 && busErrors == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

// ==== all.f ====
+incdir+logic
logic/cpuPkg.sv
logic/fetchStage.sv
logic/instructionDecoder.sv
logic/operandStage.sv
logic/frontEnd.sv
dv/frontEnd_chk.sv
dv/frontEnd_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module frontEnd_tb -f all.f -o simFrontEnd

status=0
./obj_dir/simFrontEnd > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
        echo "simulator exited with status $status"
        exit 1
fi
if grep -q "Test failed" sim.log; then
        exit 1
fi
if ! grep -q "Test passed" sim.log; then
        exit 1
fi

// ==== dv/frontEnd_cases.txt ====
// columns: word, one-hot class, rd, ra, operand, immediate flag
// class 0 marks an undefined opcode
00123abc 0000100 1 2 00000003 0
02345fff 0000008 3 4 00000005 0
03567fff 0000004 5 6 00007fff 1
04789000 0000002 7 8 00000009 0
059a8000 0000001 9 a ffff8000 1
06bcd123 0800000 b c 0000000d 0
07def001 0400000 d e fffff001 1
08f0e000 0020000 f 0 0000000e 0
09010001 0010000 0 1 00000001 1
0a12f000 0000020 1 2 0000000f 0
0b231234 0000010 2 3 00001234 1
0c340000 0000800 3 4 00000000 0
0d45ffff 0000400 4 5 ffffffff 1
0e56a5a5 2000000 5 6 0000000a 0
0f67a5a5 1000000 6 7 ffffa5a5 1
10781000 0000080 7 8 00000001 0
11890080 0000040 8 9 00000080 1
129a2000 0080000 9 a 00000002 0
13ab001f 0040000 a b 0000001f 1
14bc3000 0200000 b c 00000003 0
15cdffe0 0100000 c d ffffffe0 1
16de4000 0008000 d e 00000004 0
17ef8001 0004000 e f ffff8001 1
18f05000 0002000 f 0 00000005 0
19017ffe 0001000 0 1 00007ffe 1
1a126000 0000200 1 2 00000006 0
01230042 0000000 2 3 00000042 1
1b34c000 0000000 3 4 ffffc000 1
40567000 0000000 5 6 00000007 0
ff78ffff 0000000 7 8 ffffffff 1
